// ==== build.f ====
common/icache_pkg.sv
common/lookup_if.sv
common/refill_if.sv
hw/icache/icache_lookup.sv
hw/icache/icache_ctrl.sv
hw/apb_refill_master.sv
hw/icache_subsys.sv
verif/apb_mem_model.sv
verif/tb_icache.sv

// ==== common/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    localparam int ADDR_W    = 32;
    localparam int WORD_W    = 32;
    localparam int INDEX_W   = 4;
    localparam int INDEX_LSB = 2;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;
    localparam int TAG_W     = ADDR_W - TAG_LSB;
    localparam int NUM_LINES = 1 << INDEX_W;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_refill,
        st_respond,
        st_flush
    } ctrl_state_t;

    // byte address, word aligned: [tag | index | 2'b00]
    function automatic index_t addr_index(addr_t a);
        return a[INDEX_LSB +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(addr_t a);
        return a[TAG_LSB +: TAG_W];
    endfunction

endpackage

`default_nettype wire

// ==== common/lookup_if.sv ====
`default_nettype none

interface lookup_if;
    import icache_pkg::*;

    index_t index;
    tag_t   tag;
    logic   hit;
    word_t  rdata;
    logic   fill;
    word_t  fill_data;
    logic   inval;

    modport ctrl (
        output index,
        output tag,
        output fill,
        output fill_data,
        output inval,
        input  hit,
        input  rdata
    );

    modport array (
        input  index,
        input  tag,
        input  fill,
        input  fill_data,
        input  inval,
        output hit,
        output rdata
    );

endinterface

`default_nettype wire

// ==== common/refill_if.sv ====
`default_nettype none

interface refill_if;
    import icache_pkg::*;

    logic  req;
    addr_t addr;
    logic  done;
    word_t data;
    logic  err;

    modport ctrl (
        output req,
        output addr,
        input  done,
        input  data,
        input  err
    );

    modport master (
        input  req,
        input  addr,
        output done,
        output data,
        output err
    );

endinterface

`default_nettype wire

// ==== hw/apb_refill_master.sv ====
`default_nettype none

module apb_refill_master (
    input wire                    clk,
    input wire                    rst,
    refill_if.master              rf,
    output icache_pkg::addr_t     paddr,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    input wire icache_pkg::word_t prdata,
    input wire logic              pready,
    input wire logic              pslverr
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        ph_idle,
        ph_setup,
        ph_access
    } apb_phase_t;

    apb_phase_t phase_q;
    logic       done_q;
    word_t      data_q;
    logic       err_q;

    // req is still high in the done cycle, so wait for it to drop
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase_q <= ph_idle;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (phase_q)
                ph_idle:   if (rf.req && !done_q) phase_q <= ph_setup;
                ph_setup:  phase_q <= ph_access;
                ph_access:
                begin
                    if (pready)
                    begin
                        phase_q <= ph_idle;
                        done_q  <= 1'b1;
                    end
                end
                default:   phase_q <= ph_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (phase_q == ph_idle && rf.req)
            paddr <= rf.addr;
        if (phase_q == ph_access && pready)
        begin
            data_q <= prdata;
            err_q  <= pslverr;
        end
    end

    assign psel    = (phase_q != ph_idle);
    assign penable = (phase_q == ph_access);
    assign pwrite  = 1'b0;

    assign rf.done = done_q;
    assign rf.data = data_q;
    assign rf.err  = err_q;

    a_access_stable: assert property (
        @(posedge clk) disable iff (rst)
        psel && penable && !pready |=> psel && $stable(paddr)
    );

    // access only inside a selected transfer that was already running
    a_enable_in_sel: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel && $past(psel)
    );

endmodule

`default_nettype wire

// ==== hw/icache/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl (
    input wire               clk,
    input wire               rst,
    input wire logic         cpu_req_valid,
    input wire icache_pkg::addr_t cpu_req_addr,
    output logic             cpu_req_ready,
    input wire logic         flush,
    output logic             cpu_resp_valid,
    output icache_pkg::word_t cpu_resp_data,
    output logic             cpu_resp_err,
    lookup_if.ctrl           lk,
    refill_if.ctrl           rf
);
    import icache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    addr_t       addr_q;

    // flush wins over a request in the same cycle
    assign cpu_req_ready = (state_q == st_idle) && !flush;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            st_idle:
            begin
                if (flush)
                    state_d = st_flush;
                else if (cpu_req_valid)
                    state_d = st_compare;
            end
            st_compare: state_d = lk.hit ? st_respond : st_refill;
            st_refill:  state_d = rf.done ? st_respond : st_refill;
            st_respond: state_d = st_idle;
            st_flush:   state_d = st_idle;
            default:    state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state_q <= st_idle;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk)
    begin
        if (cpu_req_valid && cpu_req_ready)
            addr_q <= cpu_req_addr;
    end

    // lookup and fill side
    assign lk.index     = addr_index(addr_q);
    assign lk.tag       = addr_tag(addr_q);
    assign lk.inval     = (state_q == st_flush);
    assign lk.fill      = (state_q == st_refill) && rf.done && !rf.err;
    assign lk.fill_data = rf.data;

    assign rf.req  = (state_q == st_refill);
    assign rf.addr = addr_q;

    // response register is valid for the respond cycle only
    always_ff @(posedge clk)
    begin
        if (rst)
            cpu_resp_valid <= 1'b0;
        else
            cpu_resp_valid <= (state_q == st_compare && lk.hit) ||
                              (state_q == st_refill && rf.done);
    end

    always_ff @(posedge clk)
    begin
        if (state_q == st_compare && lk.hit)
        begin
            cpu_resp_data <= lk.rdata;
            cpu_resp_err  <= 1'b0;
        end
        else if (state_q == st_refill && rf.done)
        begin
            cpu_resp_data <= rf.data;
            cpu_resp_err  <= rf.err;
        end
    end

    a_resp_single: assert property (
        @(posedge clk) disable iff (rst)
        cpu_resp_valid |=> !cpu_resp_valid
    );

    // refill request and address held across APB wait states
    a_req_until_done: assert property (
        @(posedge clk) disable iff (rst)
        rf.req && !rf.done |=> rf.req && $stable(rf.addr)
    );

endmodule

`default_nettype wire

// ==== hw/icache/icache_lookup.sv ====
`default_nettype none

module icache_lookup (
    input wire      clk,
    input wire      rst,
    lookup_if.array lk
);
    import icache_pkg::*;

    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_q  [NUM_LINES];
    word_t                data_q [NUM_LINES];

    // valid bits
    always_ff @(posedge clk)
    begin
        if (rst || lk.inval)
        begin
            valid_q <= '0;
        end
        else if (lk.fill)
        begin
            valid_q[lk.index] <= 1'b1;
        end
    end

    // tag and data arrays, written on fill only
    always_ff @(posedge clk)
    begin
        if (lk.fill)
        begin
            tag_q[lk.index]  <= lk.tag;
            data_q[lk.index] <= lk.fill_data;
        end
    end

    always_comb
    begin
        lk.hit   = valid_q[lk.index] && (tag_q[lk.index] == lk.tag);
        lk.rdata = data_q[lk.index];
    end

    // a fill racing a fence.i would leave a stale line behind
    a_fill_inval_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(lk.fill && lk.inval)
    );

endmodule

`default_nettype wire

// ==== hw/icache_subsys.sv ====
`default_nettype none

module icache_subsys (
    input wire                    clk,
    input wire                    rst,
    input wire logic              cpu_req_valid,
    input wire icache_pkg::addr_t cpu_req_addr,
    output logic                  cpu_req_ready,
    input wire logic              flush,
    output logic                  cpu_resp_valid,
    output icache_pkg::word_t     cpu_resp_data,
    output logic                  cpu_resp_err,
    output icache_pkg::addr_t     paddr,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    input wire icache_pkg::word_t prdata,
    input wire logic              pready,
    input wire logic              pslverr
);

    lookup_if lk_if ();
    refill_if rf_if ();

    icache_lookup u_lookup (
        .clk (clk),
        .rst (rst),
        .lk  (lk_if.array)
    );

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_ready  (cpu_req_ready),
        .flush          (flush),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_data  (cpu_resp_data),
        .cpu_resp_err   (cpu_resp_err),
        .lk             (lk_if.ctrl),
        .rf             (rf_if.ctrl)
    );

    // memory side, one APB read per miss
    apb_refill_master u_apb (
        .clk     (clk),
        .rst     (rst),
        .rf      (rf_if.master),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_icache -f build.f --Mdir "$OBJ" -o sim_icache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/sim_icache" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "testbench reported a failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

// ==== verif/apb_mem_model.sv ====
`default_nettype none

module apb_mem_model (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [31:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic [31:0]      xfer_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] ERR_BASE  = 32'hF000_0000;
    localparam logic [31:0] DATA_MASK = 32'h5A5A_5A5A;
    localparam int          MAX_WAIT  = 3;

    logic        ready_q  = 1'b0;
    logic [31:0] data_q   = 32'd0;
    logic        err_q    = 1'b0;
    logic [1:0]  wait_cnt = 2'd0;
    logic [31:0] xfer_q   = 32'd0;

    // wait states drawn in the setup cycle, counted down in access
    always @(posedge clk)
    begin
        logic [1:0] left;
        if (rst)
        begin
            ready_q  <= 1'b0;
            err_q    <= 1'b0;
            wait_cnt <= 2'd0;
            xfer_q   <= 32'd0;
        end
        else if (psel && penable && ready_q)
        begin
            ready_q <= 1'b0;
            xfer_q  <= xfer_q + 32'd1;
        end
        else if (psel)
        begin
            if (!penable)
                left = 2'($urandom_range(MAX_WAIT, 0));
            else
                left = wait_cnt - 2'd1;
            wait_cnt <= left;
            if (left == 2'd0)
            begin
                ready_q <= 1'b1;
                // inverted word address, then the fixed pattern
                data_q  <= ~(paddr >> 2) ^ DATA_MASK;
                // read-only memory rejects writes
                err_q   <= pwrite || (paddr >= ERR_BASE);
            end
        end
    end

    assign pready     = ready_q;
    assign prdata     = data_q;
    assign pslverr    = err_q;
    assign xfer_count = xfer_q;

endmodule

`default_nettype wire

// ==== verif/tb_icache.sv ====
`default_nettype none

module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 10;
    localparam int SEED            = 51326;
    localparam int NUM_DIRECTED    = 10;
    localparam int NUM_RANDOM      = 200;
    localparam int MISS_CYCLES     = 12;
    localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * MISS_CYCLES + 200;

    logic        clk;
    logic        rst;
    logic        cpu_req_valid;
    logic [31:0] cpu_req_addr;
    logic        cpu_req_ready;
    logic        flush;
    logic        cpu_resp_valid;
    logic [31:0] cpu_resp_data;
    logic        cpu_resp_err;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] xfer_count;

    // request in flight and what it should return
    string       test_name;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic        exp_err;
    logic        exp_hit;
    logic [31:0] exp_xfers;
    logic        req_seen;
    logic [7:0]  lat = 8'd0;
    logic        in_flight = 1'b0;

    // shadow valid/tag table
    logic        sh_valid [16];
    logic [25:0] sh_tag   [16];

    icache_subsys dut (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_ready  (cpu_req_ready),
        .flush          (flush),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_data  (cpu_resp_data),
        .cpu_resp_err   (cpu_resp_err),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr)
    );

    apb_mem_model u_mem (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .xfer_count (xfer_count)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s: expected %h, actual %h", name, expected, actual);
        $display("Simulation FAILED");
        $fatal(1, "check failed in %s", name);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    // cycles since the accepting edge
    always @(posedge clk)
    begin
        if (cpu_req_valid && cpu_req_ready)
            lat <= 8'd1;
        else if (lat != 8'hff)
            lat <= lat + 8'd1;
    end

    // accepted and not yet answered
    always @(posedge clk)
    begin
        if (cpu_req_valid && cpu_req_ready)
            in_flight <= 1'b1;
        else if (cpu_resp_valid)
            in_flight <= 1'b0;
    end

    a_resp_data: assert property (@(posedge clk) disable iff (rst)
        cpu_resp_valid && !exp_err |-> cpu_resp_data == exp_data)
        else report_mismatch(test_name, exp_data, cpu_resp_data);

    a_resp_err: assert property (@(posedge clk) disable iff (rst)
        cpu_resp_valid |-> cpu_resp_err == exp_err)
        else report_mismatch(test_name, {31'b0, exp_err}, {31'b0, cpu_resp_err});

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        cpu_resp_valid && exp_hit |-> lat == 8'd2)
        else report_mismatch(test_name, 32'd2, {24'b0, lat});

    a_miss_latency: assert property (@(posedge clk) disable iff (rst)
        cpu_resp_valid && !exp_hit |-> lat > 8'd2)
        else abort_run("miss answered as fast as a hit");

    a_ready_busy: assert property (@(posedge clk) disable iff (rst)
        in_flight |-> !cpu_req_ready)
        else abort_run("cache ready while a request is in flight");

    // one APB read per miss, none per hit
    a_xfer_count: assert property (@(posedge clk) disable iff (rst)
        cpu_resp_valid |-> xfer_count == exp_xfers)
        else report_mismatch(test_name, exp_xfers, xfer_count);

    a_paddr: assert property (@(posedge clk) disable iff (rst)
        psel && penable && pready |-> paddr == exp_addr)
        else report_mismatch(test_name, exp_addr, paddr);

    a_no_write: assert property (@(posedge clk) disable iff (rst)
        psel |-> !pwrite)
        else abort_run("APB write seen from a read-only cache");

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !req_seen |-> !psel && !cpu_resp_valid)
        else abort_run("bus or response active before the first request");

    task automatic issue_request(input string name, input logic [31:0] a);
        logic [3:0]  idx;
        logic [25:0] tg;
        idx = a[5:2];
        tg  = a[31:6];
        @(posedge clk);
        test_name = name;
        exp_addr  = a;
        exp_err   = (a >= 32'hF000_0000);
        exp_hit   = sh_valid[idx] && (sh_tag[idx] == tg);
        exp_data  = {2'b11, ~a[31:2]} ^ 32'h5A5A_5A5A;
        if (!exp_hit)
            exp_xfers = exp_xfers + 32'd1;
        // error responses leave the line alone
        if (!exp_hit && !exp_err)
        begin
            sh_valid[idx] = 1'b1;
            sh_tag[idx]   = tg;
        end
        req_seen = 1'b1;
        cpu_req_valid <= 1'b1;
        cpu_req_addr  <= a;
        do
            @(posedge clk);
        while (!cpu_req_ready);
        cpu_req_valid <= 1'b0;
        do
            @(posedge clk);
        while (!cpu_resp_valid);
    endtask

    task automatic flush_cache();
        @(posedge clk);
        test_name = "flush";
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int i = 0; i < 16; i++)
            sh_valid[i] = 1'b0;
    endtask

    task automatic run_random_mix();
        logic [25:0] tg;
        logic [3:0]  idx;
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            case ($urandom_range(3, 0))
                0:       tg = 26'h000_0041;
                1:       tg = 26'h000_0082;
                2:       tg = 26'h012_3456;
                default: tg = 26'h3C0_0000;
            endcase
            idx = 4'($urandom_range(15, 0));
            issue_request("random_mix", {tg, idx, 2'b00});
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before all requests were answered");
    end

    initial
    begin
        void'($urandom(SEED));
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req_addr  = 32'd0;
        flush         = 1'b0;
        test_name     = "reset";
        exp_addr      = 32'd0;
        exp_data      = 32'd0;
        exp_err       = 1'b0;
        exp_hit       = 1'b0;
        exp_xfers     = 32'd0;
        req_seen      = 1'b0;
        for (int i = 0; i < 16; i++)
        begin
            sh_valid[i] = 1'b0;
            sh_tag[i]   = 26'd0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        issue_request("cold_miss", 32'h0000_1044);
        issue_request("hit", 32'h0000_1044);
        // same index, different tag
        issue_request("conflict", 32'h0000_2044);
        issue_request("conflict", 32'h0000_1044);
        issue_request("conflict", 32'h0000_2044);
        issue_request("conflict", 32'h0000_1044);
        issue_request("error", 32'hF000_0010);
        issue_request("error", 32'hF000_0010);
        issue_request("flush", 32'h0000_30BC);
        flush_cache();
        issue_request("flush", 32'h0000_30BC);
        run_random_mix();

        repeat (4) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
